// File: include/alloc_macros.svh
// Group width and register counts are fixed; all widths in alloc_pkg derive from these
`ifndef ALLOC_MACROS_SVH
`define ALLOC_MACROS_SVH

// Instructions per group
`define ALLOC_WIDTH 4

// Physical register file size
`define PREG_COUNT 64

// Architectural registers, mapped 1:1 onto the low physical registers at reset
`define AREG_COUNT 32

// Outstanding branches that can hold a free-list checkpoint
`define BR_DEPTH 8

`endif

// File: logic/alloc_pkg.sv
// Slots arrive already classified by the decoder; at most one branch per group is supported
`include "alloc_macros.svh"

package alloc_pkg;

   typedef logic [$clog2(`PREG_COUNT)-1:0]  preg_t;
   typedef logic [$clog2(`AREG_COUNT)-1:0]  areg_t;

   // Extra top bit tells a full ring from an empty one
   typedef logic [$clog2(`PREG_COUNT):0]    fl_pos_t;

   typedef logic [$clog2(`BR_DEPTH)-1:0]    br_tag_t;
   typedef logic [$clog2(`ALLOC_WIDTH)-1:0] slot_idx_t;
   typedef logic [`ALLOC_WIDTH-1:0]         slot_mask_t;

   typedef struct packed {
      logic    valid;
      logic    writes_reg;
      logic    is_branch;
      logic    is_load;
      logic    is_store;
      logic    pred_taken;
      areg_t   dest;
      br_tag_t br_tag;
   } slot_in_t;

   typedef struct packed {
      logic  valid;
      logic  writes_reg;
      areg_t dest;
      preg_t pdest;
   } slot_out_t;

   // One bit per slot for the reorder buffer
   typedef struct packed {
      slot_mask_t reg_write;
      slot_mask_t ld_en;
      slot_mask_t st_en;
      slot_mask_t spec;
      slot_mask_t pred_res;
   } rob_flags_t;

endpackage

// File: logic/alloc_decode.sv
// Only the first valid branch in a group gets a checkpoint; writes to register 0 get no preg
`timescale 1ns/100ps
`include "alloc_macros.svh"

module alloc_decode (
   input  alloc_pkg::slot_in_t   group [`ALLOC_WIDTH],
   output alloc_pkg::slot_mask_t need,
   output logic                  br_slot_valid,
   output alloc_pkg::slot_idx_t  br_slot,
   output alloc_pkg::br_tag_t    br_tag,
   output alloc_pkg::rob_flags_t rob_flags
);

   import alloc_pkg::*;

   slot_mask_t br_mask;

   always_comb begin
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         need[i] = group[i].valid && group[i].writes_reg &&
                   (group[i].dest != areg_t'(0));
         br_mask[i] = group[i].valid && group[i].is_branch;

         rob_flags.reg_write[i] = need[i];
         rob_flags.ld_en[i]     = group[i].valid && group[i].is_load;
         rob_flags.st_en[i]     = group[i].valid && group[i].is_store;
         rob_flags.spec[i]      = br_mask[i];
         rob_flags.pred_res[i]  = br_mask[i] && group[i].pred_taken;
      end
   end

   // Lowest slot wins, scanned from the top down
   always_comb begin
      br_slot_valid = 1'b0;
      br_slot       = '0;
      br_tag        = '0;
      for (int i = `ALLOC_WIDTH - 1; i >= 0; i--) begin
         if (br_mask[i]) begin
            br_slot_valid = 1'b1;
            br_slot       = slot_idx_t'(i);
            br_tag        = group[i].br_tag;
         end
      end
   end

   // Decoder must split groups so the checkpoint table sees one branch at a time
   always_comb begin
      one_branch_per_group: assert final ($countones(br_mask) <= 1)
         else $error("more than one branch in an allocation group");
   end

endmodule

// File: logic/free_list.sv
// Each preg must be released exactly once and rel_count must not exceed the group width
`timescale 1ns/100ps
`include "alloc_macros.svh"

module free_list (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         accept,
   input  alloc_pkg::slot_mask_t        need,
   input  logic [$clog2(`ALLOC_WIDTH):0] rel_count,
   input  alloc_pkg::preg_t             rel_preg [`ALLOC_WIDTH],
   input  logic                         flush,
   input  alloc_pkg::fl_pos_t           flush_pos,
   output alloc_pkg::preg_t             pdest [`ALLOC_WIDTH],
   output logic                         no_free_preg,
   output alloc_pkg::fl_pos_t           head
);

   import alloc_pkg::*;

   preg_t   ring [`PREG_COUNT];
   fl_pos_t head_q;
   fl_pos_t tail_q;
   fl_pos_t free_cnt;

   // Needing slots taken so far in this group
   logic [$clog2(`ALLOC_WIDTH):0] run;

   assign head     = head_q;
   assign free_cnt = tail_q - head_q;

   // Full group must always fit, so this ignores need
   assign no_free_preg = free_cnt < fl_pos_t'(`ALLOC_WIDTH);

   always_comb begin
      run = '0;
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         pdest[i] = ring[preg_t'(head_q + fl_pos_t'(run))];
         if (need[i]) begin
            run = run + 1'b1;
         end
      end
   end

   // Low half starts mapped to the architectural registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `PREG_COUNT; i++) begin
            ring[i] <= preg_t'(i);
         end
      end else begin
         for (int i = 0; i < `ALLOC_WIDTH; i++) begin
            if (i < int'(rel_count)) begin
               ring[preg_t'(tail_q + fl_pos_t'(i))] <= rel_preg[i];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head_q <= fl_pos_t'(`AREG_COUNT);
         tail_q <= fl_pos_t'(`PREG_COUNT);
      end else begin
         // Releases land on every edge
         tail_q <= tail_q + fl_pos_t'(rel_count);
         if (flush) begin
            head_q <= flush_pos;
         end else if (accept) begin
            head_q <= head_q + fl_pos_t'($countones(need));
         end
      end
   end

   // Commit side and checkpoint restores must never overfill the ring
   free_cnt_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      free_cnt <= fl_pos_t'(`PREG_COUNT)
   ) else $error("free list count above %0d", `PREG_COUNT);

endmodule

// File: logic/branch_checkpoint.sv
// A misprediction discards every checkpoint; commit and mis_pred tags must name live entries
`timescale 1ns/100ps
`include "alloc_macros.svh"

module branch_checkpoint (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  accept,
   input  alloc_pkg::slot_mask_t need,
   input  logic                  br_slot_valid,
   input  alloc_pkg::slot_idx_t  br_slot,
   input  alloc_pkg::br_tag_t    br_tag,
   input  alloc_pkg::fl_pos_t    head,
   input  logic                  mis_pred,
   input  alloc_pkg::br_tag_t    mis_tag,
   input  logic                  br_commit,
   input  alloc_pkg::br_tag_t    commit_tag,
   output logic                  flush,
   output alloc_pkg::fl_pos_t    flush_pos,
   output logic                  br_full
);

   import alloc_pkg::*;

   fl_pos_t                    cp_pos [`BR_DEPTH];
   logic [`BR_DEPTH-1:0]       cp_valid;
   logic [$clog2(`BR_DEPTH):0] br_cnt;
   logic [$clog2(`ALLOC_WIDTH):0] pre_cnt;
   logic                       store_en;

   assign store_en  = accept && br_slot_valid;
   assign flush     = mis_pred;
   assign flush_pos = cp_pos[mis_tag];
   assign br_full   = (br_cnt == `BR_DEPTH);

   // Branch slot's own allocation stays behind the checkpoint
   always_comb begin
      pre_cnt = '0;
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         if (i <= int'(br_slot) && need[i]) begin
            pre_cnt = pre_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (store_en) begin
         cp_pos[br_tag] <= head + fl_pos_t'(pre_cnt);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || mis_pred) begin
         cp_valid <= '0;
         br_cnt   <= '0;
      end else begin
         if (store_en) begin
            cp_valid[br_tag] <= 1'b1;
         end
         if (br_commit) begin
            cp_valid[commit_tag] <= 1'b0;
         end
         if (store_en && !br_commit) begin
            br_cnt <= br_cnt + 1'b1;
         end else if (!store_en && br_commit) begin
            br_cnt <= br_cnt - 1'b1;
         end
      end
   end

   // Commit stage may only resolve branches this stage checkpointed
   mis_tag_live: assert property (
      @(posedge clk) disable iff (!rst_n)
      mis_pred |-> cp_valid[mis_tag]
   ) else $error("misprediction on tag %0d with no checkpoint", mis_tag);

   commit_tag_live: assert property (
      @(posedge clk) disable iff (!rst_n)
      (br_commit && !mis_pred) |-> cp_valid[commit_tag]
   ) else $error("commit of tag %0d with no checkpoint", commit_tag);

endmodule

// File: logic/alloc_combine.sv
// Slots without a register need carry pdest zero; a held group goes out as all zeros
`timescale 1ns/100ps
`include "alloc_macros.svh"

module alloc_combine (
   input  alloc_pkg::slot_in_t   group [`ALLOC_WIDTH],
   input  alloc_pkg::slot_mask_t need,
   input  alloc_pkg::preg_t      pdest [`ALLOC_WIDTH],
   input  logic                  accept,
   output alloc_pkg::slot_out_t  sched_out [`ALLOC_WIDTH],
   output logic                  all_nop
);

   import alloc_pkg::*;

   logic any_valid;

   always_comb begin
      any_valid = 1'b0;
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         if (accept) begin
            sched_out[i] = slot_out_t'{
               valid:      group[i].valid,
               writes_reg: group[i].writes_reg,
               dest:       group[i].dest,
               pdest:      need[i] ? pdest[i] : preg_t'(0)
            };
         end else begin
            sched_out[i] = '0;
         end
         any_valid = any_valid | group[i].valid;
      end
   end

   // Tells the scheduler and ROB to skip this cycle
   assign all_nop = !accept || !any_valid;

endmodule

// File: logic/alloc_stage.sv
// A group is taken in every cycle with no hold, no free-list shortage, free tag and no flush
`timescale 1ns/100ps
`include "alloc_macros.svh"

module alloc_stage (
   input  logic                          clk,
   input  logic                          rst_n,
   input  alloc_pkg::slot_in_t           group [`ALLOC_WIDTH],
   input  logic                          stall,
   input  logic                          sched_full,
   input  logic [$clog2(`ALLOC_WIDTH):0] rel_count,
   input  alloc_pkg::preg_t              rel_preg [`ALLOC_WIDTH],
   input  logic                          mis_pred,
   input  alloc_pkg::br_tag_t            mis_tag,
   input  logic                          br_commit,
   input  alloc_pkg::br_tag_t            commit_tag,
   output alloc_pkg::slot_out_t          sched_out [`ALLOC_WIDTH],
   output alloc_pkg::rob_flags_t         rob_flags,
   output logic                          all_nop,
   output logic                          no_free_preg
);

   import alloc_pkg::*;

   logic       hold;
   logic       accept;
   slot_mask_t need;
   rob_flags_t rob_flags_dec;
   logic       br_slot_valid;
   slot_idx_t  br_slot;
   br_tag_t    br_tag;
   preg_t      pdest [`ALLOC_WIDTH];
   fl_pos_t    head;
   logic       flush;
   fl_pos_t    flush_pos;
   logic       br_full;

   assign hold   = stall | sched_full;
   assign accept = !hold && !no_free_preg && !br_full && !flush;

   // ROB flags are blanked together with the scheduler group
   assign rob_flags = accept ? rob_flags_dec : '0;

   alloc_decode alloc_decode_i (
      .group         (group),
      .need          (need),
      .br_slot_valid (br_slot_valid),
      .br_slot       (br_slot),
      .br_tag        (br_tag),
      .rob_flags     (rob_flags_dec)
   );

   free_list free_list_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .accept       (accept),
      .need         (need),
      .rel_count    (rel_count),
      .rel_preg     (rel_preg),
      .flush        (flush),
      .flush_pos    (flush_pos),
      .pdest        (pdest),
      .no_free_preg (no_free_preg),
      .head         (head)
   );

   branch_checkpoint branch_checkpoint_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .accept        (accept),
      .need          (need),
      .br_slot_valid (br_slot_valid),
      .br_slot       (br_slot),
      .br_tag        (br_tag),
      .head          (head),
      .mis_pred      (mis_pred),
      .mis_tag       (mis_tag),
      .br_commit     (br_commit),
      .commit_tag    (commit_tag),
      .flush         (flush),
      .flush_pos     (flush_pos),
      .br_full       (br_full)
   );

   alloc_combine alloc_combine_i (
      .group     (group),
      .need      (need),
      .pdest     (pdest),
      .accept    (accept),
      .sched_out (sched_out),
      .all_nop   (all_nop)
   );

endmodule

// File: dv/alloc_stage_tb.sv
// Run from the project root so dv/alloc_input.txt is found; one input line is one clock cycle
`timescale 1ns/100ps
`include "alloc_macros.svh"

module alloc_stage_tb;

   import alloc_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int RESET_LIMIT  = 20;
   localparam int FIELD_COUNT  = 25;

   // Column positions after the test name
   localparam int F_STALL       = 0;
   localparam int F_SCHED_FULL  = 1;
   localparam int F_REL_COUNT   = 2;
   localparam int F_REL         = 3;
   localparam int F_MIS_PRED    = 7;
   localparam int F_MIS_TAG     = 8;
   localparam int F_BR_COMMIT   = 9;
   localparam int F_COMMIT_TAG  = 10;
   localparam int F_SLOT        = 11;
   localparam int F_EXP_PDEST   = 19;
   localparam int F_EXP_NOP     = 23;
   localparam int F_EXP_NO_FREE = 24;

   logic                          clk;
   logic                          rst_n;
   slot_in_t                      group [`ALLOC_WIDTH];
   logic                          stall;
   logic                          sched_full;
   logic [$clog2(`ALLOC_WIDTH):0] rel_count;
   preg_t                         rel_preg [`ALLOC_WIDTH];
   logic                          mis_pred;
   br_tag_t                       mis_tag;
   logic                          br_commit;
   br_tag_t                       commit_tag;
   slot_out_t                     sched_out [`ALLOC_WIDTH];
   rob_flags_t                    rob_flags;
   logic                          all_nop;
   logic                          no_free_preg;

   int fields [FIELD_COUNT];
   int error_count;
   int test_errors;
   int tests_passed;
   int tests_failed;

   alloc_stage alloc_stage_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .group        (group),
      .stall        (stall),
      .sched_full   (sched_full),
      .rel_count    (rel_count),
      .rel_preg     (rel_preg),
      .mis_pred     (mis_pred),
      .mis_tag      (mis_tag),
      .br_commit    (br_commit),
      .commit_tag   (commit_tag),
      .sched_out    (sched_out),
      .rob_flags    (rob_flags),
      .all_nop      (all_nop),
      .no_free_preg (no_free_preg)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Slot kinds as listed in the input file
   function automatic slot_in_t make_slot(input int kind, input int arg);
      slot_in_t slot;
      slot = '0;
      if (kind != 0) begin
         slot.valid = 1'b1;
      end
      if (kind == 1) begin
         slot.writes_reg = 1'b1;
         slot.dest       = areg_t'(arg);
      end else if (kind == 2) begin
         slot.is_branch = 1'b1;
         slot.br_tag    = br_tag_t'(arg);
      end
      return slot;
   endfunction

   // ROB masks for the slot kinds of the current line
   function automatic rob_flags_t expect_flags(input logic taken);
      rob_flags_t want;
      int         kind;
      int         arg;
      want = '0;
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         kind = fields[F_SLOT + 2 * i];
         arg  = fields[F_SLOT + 2 * i + 1];
         if (taken) begin
            want.reg_write[i] = (kind == 1) && (arg != 0);
            want.spec[i]      = (kind == 2);
         end
      end
      return want;
   endfunction

   task automatic drive_line();
      stall      <= (fields[F_STALL] != 0);
      sched_full <= (fields[F_SCHED_FULL] != 0);
      rel_count  <= fields[F_REL_COUNT][2:0];
      mis_pred   <= (fields[F_MIS_PRED] != 0);
      mis_tag    <= br_tag_t'(fields[F_MIS_TAG]);
      br_commit  <= (fields[F_BR_COMMIT] != 0);
      commit_tag <= br_tag_t'(fields[F_COMMIT_TAG]);
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         rel_preg[i] <= preg_t'(fields[F_REL + i]);
         group[i]    <= make_slot(fields[F_SLOT + 2 * i], fields[F_SLOT + 2 * i + 1]);
      end
   endtask

   task automatic report_mismatch(input string test, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
      $display("FAIL %s %s: expected %0d, actual %0d", test, what, expected, actual);
      error_count++;
      test_errors++;
   endtask

   task automatic check_line(input string test);
      logic       taken;
      int         kind;
      int         arg;
      logic       want_valid;
      logic       want_write;
      areg_t      want_dest;
      rob_flags_t want_flags;
      // A held or empty group is flagged all_nop and goes out as zeros
      taken = (fields[F_EXP_NOP] == 0);
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         kind       = fields[F_SLOT + 2 * i];
         arg        = fields[F_SLOT + 2 * i + 1];
         want_valid = taken && (kind != 0);
         want_write = taken && (kind == 1);
         want_dest  = want_write ? areg_t'(arg) : areg_t'(0);
         if (sched_out[i].valid !== want_valid) begin
            report_mismatch(test, $sformatf("valid[%0d]", i),
                            want_valid, sched_out[i].valid);
         end
         if (sched_out[i].writes_reg !== want_write) begin
            report_mismatch(test, $sformatf("writes_reg[%0d]", i),
                            want_write, sched_out[i].writes_reg);
         end
         if (sched_out[i].dest !== want_dest) begin
            report_mismatch(test, $sformatf("dest[%0d]", i),
                            want_dest, sched_out[i].dest);
         end
         if (sched_out[i].pdest !== preg_t'(fields[F_EXP_PDEST + i])) begin
            report_mismatch(test, $sformatf("pdest[%0d]", i),
                            fields[F_EXP_PDEST + i], sched_out[i].pdest);
         end
      end
      want_flags = expect_flags(taken);
      if (rob_flags !== want_flags) begin
         report_mismatch(test, "rob_flags", want_flags, rob_flags);
      end
      if (all_nop !== (fields[F_EXP_NOP] != 0)) begin
         report_mismatch(test, "all_nop", fields[F_EXP_NOP], all_nop);
      end
      if (no_free_preg !== (fields[F_EXP_NO_FREE] != 0)) begin
         report_mismatch(test, "no_free_preg", fields[F_EXP_NO_FREE], no_free_preg);
      end
   endtask

   task automatic close_test(input string test);
      if (test_errors == 0) begin
         $display("RESULT %s passed", test);
         tests_passed++;
      end else begin
         $display("RESULT %s failed with %0d errors", test, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      stall      = 1'b0;
      sched_full = 1'b0;
      rel_count  = '0;
      mis_pred   = 1'b0;
      mis_tag    = '0;
      br_commit  = 1'b0;
      commit_tag = '0;
      for (int i = 0; i < `ALLOC_WIDTH; i++) begin
         group[i]    = '0;
         rel_preg[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

   initial begin
      int    fd;
      int    waited;
      int    code;
      logic  done;
      logic  bad;
      string tok;
      string cur_name;
      string rest;

      error_count  = 0;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      waited       = 0;
      while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was still asserted after %0d cycles", RESET_LIMIT);
         $display("TESTBENCH FAILED");
         $finish;
      end else begin
         fd = $fopen("dv/alloc_input.txt", "r");
         if (fd == 0) begin
            $display("Could not open dv/alloc_input.txt");
            error_count++;
         end else begin
            done     = 1'b0;
            cur_name = "";
            while (!done) begin
               code = $fscanf(fd, "%s", tok);
               if (code != 1) begin
                  done = 1'b1;
               end else if (tok.getc(0) == "#") begin
                  code = $fgets(rest, fd);
               end else begin
                  bad = 1'b0;
                  for (int i = 0; i < FIELD_COUNT; i++) begin
                     code = $fscanf(fd, "%d", fields[i]);
                     if (code != 1) begin
                        bad = 1'b1;
                     end
                  end
                  if (bad) begin
                     $display("Input line for %s has missing or bad fields", tok);
                     error_count++;
                     done = 1'b1;
                  end else begin
                     if (tok != cur_name) begin
                        if (cur_name != "") begin
                           close_test(cur_name);
                        end
                        cur_name = tok;
                     end
                     @(posedge clk);
                     drive_line();
                     // Outputs settle well before the falling edge
                     @(negedge clk);
                     check_line(tok);
                  end
               end
            end
            if (cur_name != "") begin
               close_test(cur_name);
            end
            $fclose(fd);
         end
         if (tests_passed + tests_failed == 0) begin
            $display("No test lines were read from the input file");
            error_count++;
         end
         $display("Tests: %0d passed, %0d failed, %0d failed checks",
                  tests_passed, tests_failed, error_count);
         if (error_count == 0) begin
            $display("TESTBENCH PASSED");
         end else begin
            $display("TESTBENCH FAILED");
         end
         $finish;
      end
   end

endmodule

// File: vlog.f
+incdir+include
logic/alloc_pkg.sv
logic/alloc_decode.sv
logic/free_list.sv
logic/branch_checkpoint.sv
logic/alloc_combine.sv
logic/alloc_stage.sv
dv/alloc_stage_tb.sv

// File: dv/alloc_input.txt
# test stall sched_full rel_count rel0 rel1 rel2 rel3 mis_pred mis_tag br_commit commit_tag
#   then kind,arg for slots 0-3 (0 empty, 1 write arg=dest, 2 branch arg=tag, 3 valid no write)
#   then expected pdest0 pdest1 pdest2 pdest3 all_nop no_free_preg
reset_alloc  0 0 0  0  0  0  0  0 0 0 0  1 5 0 0 0 0 0 0  32  0  0  0 0 0
need_mask    0 0 0  0  0  0  0  0 0 0 0  1 1 1 0 3 0 1 2  33  0  0 34 0 0
need_mask    0 0 0  0  0  0  0  0 0 0 0  1 3 1 4 1 6 1 7  35 36 37 38 0 0
hold         1 0 0  0  0  0  0  0 0 0 0  1 1 1 2 0 0 0 0   0  0  0  0 1 0
hold         0 1 0  0  0  0  0  0 0 0 0  1 1 1 2 0 0 0 0   0  0  0  0 1 0
hold         0 0 0  0  0  0  0  0 0 0 0  1 1 1 2 0 0 0 0  39 40  0  0 0 0
no_free      0 0 0  0  0  0  0  0 0 0 0  1 1 1 2 1 3 1 4  41 42 43 44 0 0
no_free      0 0 0  0  0  0  0  0 0 0 0  1 1 1 2 1 3 1 4  45 46 47 48 0 0
no_free      0 0 0  0  0  0  0  0 0 0 0  1 1 1 2 1 3 1 4  49 50 51 52 0 0
no_free      0 0 0  0  0  0  0  0 0 0 0  1 1 1 2 1 3 1 4  53 54 55 56 0 0
no_free      0 0 0  0  0  0  0  0 0 0 0  1 1 1 2 1 3 1 4  57 58 59 60 0 0
no_free      0 0 4  5  9  2  7  0 0 0 0  1 1 0 0 0 0 0 0   0  0  0  0 1 1
no_free      0 0 4 11 13 15 17  0 0 0 0  1 1 1 2 1 3 1 4  61 62 63  5 0 0
no_free      0 0 4 19 21 23 25  0 0 0 0  1 1 1 2 1 3 1 4   9  2  7 11 0 0
mispredict   0 0 0  0  0  0  0  0 0 0 0  1 1 2 2 1 2 1 3  13  0 15 17 0 0
mispredict   0 0 0  0  0  0  0  1 2 0 0  1 4 1 5 0 0 0 0   0  0  0  0 1 0
mispredict   0 0 4 27 29 31 33  0 0 0 0  1 4 1 5 1 6 0 0  15 17 19  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 0 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 1 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 2 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 3 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 4 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 5 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 6 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  2 7 0 0 0 0 0 0   0  0  0  0 0 0
br_full      0 0 0  0  0  0  0  0 0 0 0  1 1 0 0 0 0 0 0   0  0  0  0 1 0
br_full      0 0 0  0  0  0  0  0 0 1 0  1 1 0 0 0 0 0 0   0  0  0  0 1 0
br_full      0 0 0  0  0  0  0  0 0 0 0  1 1 0 0 0 0 0 0  21  0  0  0 0 0
